// File: flist.f
icache_pkg.sv
cache_req_decode.sv
cache_store.sv
cache_fill.sv
cache_hit_ctrl.sv
cache_result.sv
icache_top.sv
icache_sva.sv
tb_icache.sv

// File: run.sh
#!/bin/bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
  --top-module tb_icache -f flist.f -o sim_icache

out=$(./obj_dir/sim_icache)
echo "$out"

if grep -qx "Test passed" <<< "$out"; then
  exit 0
fi
exit 1

// File: tb_icache.sv
`timescale 1ns/1ps

module tb_icache;
  import icache_pkg::*;

  localparam int          WAYS        = 2;
  localparam int          SETS        = 16;
  localparam int          LINE_WORDS  = 4;
  localparam logic [31:0] MEM_PATTERN = 32'hA5C3_0F96;
  localparam int          TIMEOUT     = 200;

  logic            clk_i;
  logic            rst_ni;
  logic            req_i;
  logic [PLEN-1:0] adr_i;
  logic            cacheable_i;
  logic            misaligned_i;
  logic            pagefault_i;
  logic            access_fault_i;
  logic            flush_i;
  logic            cacheflush_req_i;
  logic            stall_o;
  logic [XLEN-1:0] parcel_o;
  logic            parcel_valid_o;
  logic            parcel_error_o;
  logic            parcel_misaligned_o;
  logic            parcel_pagefault_o;
  logic            bus_req_o;
  logic [PLEN-1:0] bus_adr_o;
  logic            bus_ack_i;
  logic            bus_err_i;
  logic [XLEN-1:0] bus_q_i;

  // separate streams for stimulus and bus delays
  logic [31:0] seed;
  logic [31:0] bus_seed;
  int          errors;
  int          tests_ok;
  int          tests_bad;
  int          bus_wait;
  // results of the last access
  logic        saw_bus;
  logic        saw_valid;
  logic        saw_err;
  logic        saw_stall;
  logic [31:0] got_data;
  int          words;

  icache_top #(
    .WAYS       (WAYS),
    .SETS       (SETS),
    .LINE_WORDS (LINE_WORDS)
  ) dut_i (.*);

  initial
  begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  // lcg step on the given state
  function automatic logic [31:0] lcg_next(inout logic [31:0] state);
    state = state * 32'd1103515245 + 32'd12345;
    return state;
  endfunction

  //////////////////////////////////////////////////
  // bus memory model
  //////////////////////////////////////////////////

  // data is address xor pattern, bit 12 region answers with err
  always @(posedge clk_i)
  begin
    if (bus_ack_i || bus_err_i)
    begin
      bus_ack_i <= 1'b0;
      bus_err_i <= 1'b0;
      bus_wait  <= int'(lcg_next(bus_seed) >> 16) % 4;
    end
    else if (bus_req_o && rst_ni)
    begin
      if (bus_wait == 0)
      begin
        bus_ack_i <= ~bus_adr_o[12];
        bus_err_i <= bus_adr_o[12];
        bus_q_i   <= bus_adr_o ^ MEM_PATTERN;
      end
      else
        bus_wait <= bus_wait - 1;
    end
  end

  //////////////////////////////////////////////////
  // helpers
  //////////////////////////////////////////////////

  task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp)
    begin
      $display("[FAIL] %0t %s got %h expected %h", $time, name, got, exp);
      errors++;
    end
  endtask

  // one request, held until valid or error, with timeout
  task automatic do_access(input logic [31:0] adr, input logic cacheable);
    int n;
    saw_bus   = 1'b0;
    saw_valid = 1'b0;
    saw_err   = 1'b0;
    saw_stall = 1'b0;
    words     = 0;
    n         = 0;
    @(posedge clk_i);
    req_i       <= 1'b1;
    adr_i       <= adr;
    cacheable_i <= cacheable;
    while (!saw_valid && !saw_err && n < TIMEOUT)
    begin
      @(posedge clk_i);
      n++;
      if (bus_req_o)
        saw_bus = 1'b1;
      if (stall_o)
        saw_stall = 1'b1;
      if (bus_req_o && (bus_ack_i || bus_err_i))
        words++;
      saw_valid = parcel_valid_o;
      saw_err   = parcel_error_o;
      got_data  = parcel_o;
    end
    req_i <= 1'b0;
    if (n >= TIMEOUT)
    begin
      $display("access to %h never completed", adr);
      errors++;
    end
  endtask

  // faulted request, flags checked in its first cycle
  task automatic fault_access(input logic mis, input logic pf, input logic af);
    @(posedge clk_i);
    req_i          <= 1'b1;
    adr_i          <= lcg_next(seed) & 32'hFFFF_EFFC;
    cacheable_i    <= 1'b1;
    misaligned_i   <= mis;
    pagefault_i    <= pf;
    access_fault_i <= af;
    @(posedge clk_i);
    check_val("parcel_misaligned_o", 32'(parcel_misaligned_o), 32'(mis));
    check_val("parcel_pagefault_o", 32'(parcel_pagefault_o), 32'(pf));
    check_val("parcel_error_o", 32'(parcel_error_o), 32'(af));
    check_val("bus_req_o", 32'(bus_req_o), 32'd0);
    check_val("parcel_valid_o", 32'(parcel_valid_o), 32'd0);
    req_i          <= 1'b0;
    misaligned_i   <= 1'b0;
    pagefault_i    <= 1'b0;
    access_fault_i <= 1'b0;
  endtask

  task automatic end_test(input string name, input int errs_before);
    if (errors == errs_before)
    begin
      $display("test %s: ok", name);
      tests_ok++;
    end
    else
    begin
      $display("test %s: failed", name);
      tests_bad++;
    end
  endtask

  //////////////////////////////////////////////////
  // test sequence
  //////////////////////////////////////////////////

  initial
  begin
    logic [31:0] a;
    logic [31:0] b;
    int          e0;
    int          n;
    int          stall_cnt;
    seed = 32'd64726;
    bus_seed = 32'd64726;
    errors = 0;
    tests_ok = 0;
    tests_bad = 0;
    bus_wait = 0;
    rst_ni = 1'b0;
    req_i = 1'b0;
    adr_i = '0;
    cacheable_i = 1'b0;
    misaligned_i = 1'b0;
    pagefault_i = 1'b0;
    access_fault_i = 1'b0;
    flush_i = 1'b0;
    cacheflush_req_i = 1'b0;
    bus_ack_i = 1'b0;
    bus_err_i = 1'b0;
    bus_q_i = '0;
    repeat (4) @(posedge clk_i);
    rst_ni <= 1'b1;

    // first access fills, neighbour word hits
    e0 = errors;
    a = lcg_next(seed) & 32'hFFFF_EFFC;
    do_access(a, 1'b1);
    check_val("bus_req_o seen", 32'(saw_bus), 32'd1);
    check_val("fill words", words, LINE_WORDS);
    check_val("parcel_o", got_data, a ^ MEM_PATTERN);
    do_access(a ^ 32'h4, 1'b1);
    check_val("bus_req_o seen", 32'(saw_bus), 32'd0);
    check_val("stall_o seen", 32'(saw_stall), 32'd0);
    check_val("parcel_o", got_data, (a ^ 32'h4) ^ MEM_PATTERN);
    end_test("miss_fill_hit", e0);

    // single reads always go out, line stays uncached
    e0 = errors;
    b = (lcg_next(seed) & 32'hFFFF_EFFC) ^ 32'h0000_0800;
    repeat (2)
    begin
      do_access(b, 1'b0);
      check_val("bus_req_o seen", 32'(saw_bus), 32'd1);
      check_val("parcel_o", got_data, b ^ MEM_PATTERN);
    end
    do_access(b, 1'b1);
    check_val("bus_req_o seen", 32'(saw_bus), 32'd1);
    check_val("fill words", words, LINE_WORDS);
    end_test("noncacheable", e0);

    // error region, fill aborts and retry goes to bus again
    e0 = errors;
    a = (lcg_next(seed) & 32'hFFFF_EFFC) | 32'h0000_1000;
    repeat (2)
    begin
      do_access(a, 1'b1);
      check_val("bus_req_o seen", 32'(saw_bus), 32'd1);
      check_val("parcel_error_o", 32'(saw_err), 32'd1);
      check_val("parcel_valid_o", 32'(saw_valid), 32'd0);
    end
    do_access(a, 1'b0);
    check_val("parcel_error_o", 32'(saw_err), 32'd1);
    end_test("bus_error", e0);

    // flush stalls 3 cycles then a known line misses
    e0 = errors;
    do_access(b, 1'b1);
    check_val("bus_req_o seen", 32'(saw_bus), 32'd0);
    @(posedge clk_i);
    cacheflush_req_i <= 1'b1;
    @(posedge clk_i);
    cacheflush_req_i <= 1'b0;
    stall_cnt = 0;
    n = 0;
    while (n < TIMEOUT && !(stall_cnt > 0 && !stall_o))
    begin
      @(posedge clk_i);
      n++;
      if (stall_o)
        stall_cnt++;
    end
    if (n >= TIMEOUT)
    begin
      $display("flush stall never ended");
      errors++;
    end
    check_val("stall_o cycles", stall_cnt, 3);
    do_access(b, 1'b1);
    check_val("bus_req_o seen", 32'(saw_bus), 32'd1);
    end_test("cache_flush", e0);

    // each fault flag on its own
    e0 = errors;
    fault_access(1'b1, 1'b0, 1'b0);
    fault_access(1'b0, 1'b1, 1'b0);
    fault_access(1'b0, 1'b0, 1'b1);
    end_test("faulted", e0);

    // random mix, data checked by the bound assertions
    e0 = errors;
    for (int i = 0; i < 40; i++)
    begin
      a = lcg_next(seed) & 32'h0000_0E7C;
      do_access(a, lcg_next(seed) % 4 != 0);
      check_val("parcel_o", got_data, a ^ MEM_PATTERN);
    end
    end_test("random_mix", e0);

    $display("tests ok %0d failed %0d errors %0d", tests_ok, tests_bad, errors);
    if (errors == 0)
      $display("Test passed");
    else
      $display("Test failed");
    $finish;
  end

  // hard limit on run time
  initial
  begin
    #200000;
    $display("simulation ran out of time");
    $display("Test failed");
    $finish;
  end

endmodule

// File: icache_sva.sv
`timescale 1ns/1ps

module icache_sva import icache_pkg::*; #(
  parameter logic [31:0] MEM_PATTERN = 32'hA5C3_0F96
) (
  input logic            clk_i,
  input logic            rst_ni,
  input logic            req_i,
  input logic [PLEN-1:0] adr_i,
  input logic            misaligned_i,
  input logic            pagefault_i,
  input logic            access_fault_i,
  input logic            stall_o,
  input logic [XLEN-1:0] parcel_o,
  input logic            parcel_valid_o,
  input logic            parcel_error_o,
  input logic            bus_req_o,
  input logic [PLEN-1:0] bus_adr_o,
  input logic            bus_ack_i,
  input logic            bus_err_i
);

  logic faulted;

  assign faulted = misaligned_i | pagefault_i | access_fault_i;

  // returned word follows the memory rule
  a_hit_data: assert property (@(posedge clk_i) disable iff (!rst_ni)
    parcel_valid_o && req_i && !faulted |-> parcel_o == (adr_i ^ MEM_PATTERN))
    else $error("returned word does not match memory");

  // an error never comes with data
  a_err_no_valid: assert property (@(posedge clk_i) disable iff (!rst_ni)
    parcel_error_o |-> !parcel_valid_o)
    else $error("error and valid raised together");

  // request and address hold until ack or err
  a_bus_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    bus_req_o && !bus_ack_i && !bus_err_i |=> bus_req_o && $stable(bus_adr_o))
    else $error("bus request dropped or moved before response");

  // faulted request while idle starts nothing
  a_fault_quiet: assert property (@(posedge clk_i) disable iff (!rst_ni)
    req_i && faulted && !stall_o |-> !bus_req_o && !parcel_valid_o)
    else $error("faulted request reached the bus or core");

endmodule

bind icache_top icache_sva sva_i (.*);

// File: icache_top.sv
`timescale 1ns/1ps

module icache_top import icache_pkg::*; #(
  parameter int WAYS       = 2,
  parameter int SETS       = 16,
  parameter int LINE_WORDS = 4
) (
  input  logic            clk_i,
  input  logic            rst_ni,
  // core request
  input  logic            req_i,
  input  logic [PLEN-1:0] adr_i,
  input  logic            cacheable_i,
  input  logic            misaligned_i,
  input  logic            pagefault_i,
  input  logic            access_fault_i,
  input  logic            flush_i,
  input  logic            cacheflush_req_i,
  // core response
  output logic            stall_o,
  output logic [XLEN-1:0] parcel_o,
  output logic            parcel_valid_o,
  output logic            parcel_error_o,
  output logic            parcel_misaligned_o,
  output logic            parcel_pagefault_o,
  // bus
  output logic            bus_req_o,
  output logic [PLEN-1:0] bus_adr_o,
  input  logic            bus_ack_i,
  input  logic            bus_err_i,
  input  logic [XLEN-1:0] bus_q_i
);

  localparam int IDX_W  = idx_bits(SETS);
  localparam int OFFS_W = offs_bits(LINE_WORDS);
  localparam int TAG_W  = tag_bits(SETS, LINE_WORDS);
  localparam int LINE_W = LINE_WORDS * XLEN;

  // decode
  logic              valid_cacheable;
  logic              valid_nc;
  logic [IDX_W-1:0]  idx;
  logic [TAG_W-1:0]  tag;
  logic [OFFS_W-1:0] offs;
  logic              misaligned;
  logic              pagefault;
  logic              fault;
  // store
  logic              hit;
  logic [LINE_W-1:0] hit_line;
  // ctrl
  hit_state_e        state;
  bus_cmd_e          cmd;
  logic              nc_req;
  logic              flush_all;
  // fill
  logic              fill_we;
  logic [IDX_W-1:0]  fill_idx;
  logic [TAG_W-1:0]  fill_tag;
  logic [LINE_W-1:0] fill_line;
  logic              fill_done;
  logic              fill_err;
  logic              word_ack;
  logic [XLEN-1:0]   word;

  //////////////////////////////////////////////////
  // decode stage
  //////////////////////////////////////////////////

  cache_req_decode #(
    .SETS       (SETS),
    .LINE_WORDS (LINE_WORDS)
  ) decode_i (
    .req_i             (req_i),
    .adr_i             (adr_i),
    .cacheable_i       (cacheable_i),
    .misaligned_i      (misaligned_i),
    .pagefault_i       (pagefault_i),
    .access_fault_i    (access_fault_i),
    .valid_req_o       (),
    .valid_cacheable_o (valid_cacheable),
    .valid_nc_o        (valid_nc),
    .idx_o             (idx),
    .tag_o             (tag),
    .offs_o            (offs),
    .misaligned_o      (misaligned),
    .pagefault_o       (pagefault),
    .fault_o           (fault)
  );

  //////////////////////////////////////////////////
  // storage, control and fill
  //////////////////////////////////////////////////

  cache_store #(
    .WAYS       (WAYS),
    .SETS       (SETS),
    .LINE_WORDS (LINE_WORDS)
  ) store_i (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .idx_i       (idx),
    .tag_i       (tag),
    .fill_we_i   (fill_we),
    .fill_idx_i  (fill_idx),
    .fill_tag_i  (fill_tag),
    .fill_line_i (fill_line),
    .flush_all_i (flush_all),
    .hit_o       (hit),
    .hit_line_o  (hit_line)
  );

  cache_hit_ctrl ctrl_i (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .valid_cacheable_i (valid_cacheable),
    .valid_nc_i        (valid_nc),
    .hit_i             (hit),
    .flush_i           (flush_i),
    .cacheflush_req_i  (cacheflush_req_i),
    .fill_done_i       (fill_done),
    .fill_err_i        (fill_err),
    .word_ack_i        (word_ack),
    .state_o           (state),
    .stall_o           (stall_o),
    .cmd_o             (cmd),
    .nc_req_o          (nc_req),
    .flush_all_o       (flush_all)
  );

  cache_fill #(
    .SETS       (SETS),
    .LINE_WORDS (LINE_WORDS)
  ) fill_i (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .cmd_i       (cmd),
    .nc_req_i    (nc_req),
    .adr_i       (adr_i),
    .bus_ack_i   (bus_ack_i),
    .bus_err_i   (bus_err_i),
    .bus_q_i     (bus_q_i),
    .bus_req_o   (bus_req_o),
    .bus_adr_o   (bus_adr_o),
    .fill_we_o   (fill_we),
    .fill_idx_o  (fill_idx),
    .fill_tag_o  (fill_tag),
    .fill_line_o (fill_line),
    .fill_done_o (fill_done),
    .fill_err_o  (fill_err),
    .word_ack_o  (word_ack),
    .word_o      (word)
  );

  //////////////////////////////////////////////////
  // result to the core
  //////////////////////////////////////////////////

  cache_result #(
    .LINE_WORDS (LINE_WORDS)
  ) result_i (
    .state_i             (state),
    .valid_cacheable_i   (valid_cacheable),
    .hit_i               (hit),
    .hit_line_i          (hit_line),
    .offs_i              (offs),
    .word_ack_i          (word_ack),
    .word_i              (word),
    .fill_err_i          (fill_err),
    .fault_i             (fault),
    .misaligned_i        (misaligned),
    .pagefault_i         (pagefault),
    .parcel_o            (parcel_o),
    .parcel_valid_o      (parcel_valid_o),
    .parcel_error_o      (parcel_error_o),
    .parcel_misaligned_o (parcel_misaligned_o),
    .parcel_pagefault_o  (parcel_pagefault_o)
  );

endmodule

// File: cache_result.sv
`timescale 1ns/1ps

module cache_result import icache_pkg::*; #(
  parameter int LINE_WORDS = 4
) (
  input  hit_state_e                       state_i,
  input  logic                             valid_cacheable_i,
  input  logic                             hit_i,
  input  logic [LINE_WORDS*XLEN-1:0]       hit_line_i,
  input  logic [offs_bits(LINE_WORDS)-1:0] offs_i,
  input  logic                             word_ack_i,
  input  logic [XLEN-1:0]                  word_i,
  input  logic                             fill_err_i,
  input  logic                             fault_i,
  input  logic                             misaligned_i,
  input  logic                             pagefault_i,
  output logic [XLEN-1:0]                  parcel_o,
  output logic                             parcel_valid_o,
  output logic                             parcel_error_o,
  output logic                             parcel_misaligned_o,
  output logic                             parcel_pagefault_o
);

  logic [XLEN-1:0] cache_q;

  // word picked out of the hit line
  assign cache_q = hit_line_i[offs_i*XLEN +: XLEN];

  // bus word wins when a single read returns
  assign parcel_o = word_ack_i ? word_i : cache_q;

  // valid only from the states that deliver data
  always_comb
  begin
    unique case (state_i)
      ARMED:        parcel_valid_o = (valid_cacheable_i & hit_i) | word_ack_i;
      NONCACHEABLE: parcel_valid_o = word_ack_i;
      default:      parcel_valid_o = 1'b0;
    endcase
  end

  // bus error or access fault
  assign parcel_error_o      = fill_err_i | fault_i;
  assign parcel_misaligned_o = misaligned_i;
  assign parcel_pagefault_o  = pagefault_i;

endmodule

// File: cache_hit_ctrl.sv
`timescale 1ns/1ps

module cache_hit_ctrl import icache_pkg::*; (
  input  logic       clk_i,
  input  logic       rst_ni,
  input  logic       valid_cacheable_i,
  input  logic       valid_nc_i,
  input  logic       hit_i,
  input  logic       flush_i,
  input  logic       cacheflush_req_i,
  input  logic       fill_done_i,
  input  logic       fill_err_i,
  input  logic       word_ack_i,
  output hit_state_e state_o,
  output logic       stall_o,
  output bus_cmd_e   cmd_o,
  output logic       nc_req_o,
  output logic       flush_all_o
);

  hit_state_e state_q;
  hit_state_e state_d;
  logic       cacheflush_q;
  logic       nc_start;
  logic       miss_start;
  logic       nc_done;

  //////////////////////////////////////////////////
  // start conditions
  //////////////////////////////////////////////////

  // pipe flush and a pending cache flush both block new bus work
  assign nc_start   = valid_nc_i & ~flush_i & ~cacheflush_q;
  assign miss_start = valid_cacheable_i & ~hit_i & ~flush_i & ~cacheflush_q;
  // single read finished, good or bad
  assign nc_done    = word_ack_i | fill_err_i;

  // cache flush held until the FLUSH state takes it
  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      cacheflush_q <= 1'b0;
    end
    else
    begin
      cacheflush_q <= cacheflush_req_i | (cacheflush_q & (state_q != FLUSH));
    end
  end

  //////////////////////////////////////////////////
  // state machine
  //////////////////////////////////////////////////

  always_comb
  begin
    state_d = state_q;
    unique case (state_q)
      ARMED:
      begin
        if (cacheflush_q)
          state_d = FLUSH;
        // zero-wait ack completes in ARMED itself
        else if (nc_start && !nc_done)
          state_d = NONCACHEABLE;
        else if (miss_start)
          state_d = READ;
      end
      FLUSH:        state_d = RECOVER0;
      // held request, so leave only on the bus response
      NONCACHEABLE: if (nc_done) state_d = ARMED;
      READ:         if (fill_done_i || fill_err_i) state_d = RECOVER0;
      // tag and data re-read after the write
      RECOVER0:     state_d = RECOVER1;
      RECOVER1:     state_d = ARMED;
      default:      state_d = ARMED;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
      state_q <= ARMED;
    else
      state_q <= state_d;
  end

  //////////////////////////////////////////////////
  // outputs
  //////////////////////////////////////////////////

  assign state_o     = state_q;
  assign flush_all_o = (state_q == FLUSH);

  // one-cycle pulse, only leaves ARMED once
  assign cmd_o = (state_q == ARMED && miss_start) ? CMD_READLINE : CMD_NOP;

  // level, stays up until the word returns
  assign nc_req_o = ((state_q == ARMED) & nc_start) | (state_q == NONCACHEABLE);

  // core stall per state
  always_comb
  begin
    unique case (state_q)
      ARMED:        stall_o = (valid_cacheable_i & ~hit_i) | (valid_nc_i & ~nc_done);
      NONCACHEABLE: stall_o = ~nc_done;
      FLUSH,
      READ,
      RECOVER0,
      RECOVER1:     stall_o = 1'b1;
      default:      stall_o = 1'b0;
    endcase
  end

endmodule

// File: cache_fill.sv
`timescale 1ns/1ps

module cache_fill import icache_pkg::*; #(
  parameter int SETS       = 16,
  parameter int LINE_WORDS = 4
) (
  input  logic                                  clk_i,
  input  logic                                  rst_ni,
  input  bus_cmd_e                              cmd_i,
  input  logic                                  nc_req_i,
  input  logic [PLEN-1:0]                       adr_i,
  input  logic                                  bus_ack_i,
  input  logic                                  bus_err_i,
  input  logic [XLEN-1:0]                       bus_q_i,
  output logic                                  bus_req_o,
  output logic [PLEN-1:0]                       bus_adr_o,
  output logic                                  fill_we_o,
  output logic [idx_bits(SETS)-1:0]             fill_idx_o,
  output logic [tag_bits(SETS, LINE_WORDS)-1:0] fill_tag_o,
  output logic [LINE_WORDS*XLEN-1:0]            fill_line_o,
  output logic                                  fill_done_o,
  output logic                                  fill_err_o,
  output logic                                  word_ack_o,
  output logic [XLEN-1:0]                       word_o
);

  localparam int IDX_W  = idx_bits(SETS);
  localparam int OFFS_W = offs_bits(LINE_WORDS);
  localparam int TAG_W  = tag_bits(SETS, LINE_WORDS);
  // line address, tag plus index
  localparam int BASE_W = PLEN - 2 - OFFS_W;

  logic                       filling_q;
  logic                       we_q;
  logic [OFFS_W-1:0]          cnt_q;
  logic [BASE_W-1:0]          base_q;
  logic [LINE_WORDS*XLEN-1:0] line_q;
  logic                       last_word;

  assign last_word = (cnt_q == OFFS_W'(LINE_WORDS - 1));

  //////////////////////////////////////////////////
  // line sequencer
  //////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      filling_q <= 1'b0;
      we_q      <= 1'b0;
      cnt_q     <= '0;
    end
    else
    begin
      we_q <= 1'b0;
      if (cmd_i == CMD_READLINE)
      begin
        filling_q <= 1'b1;
        cnt_q     <= '0;
      end
      else if (filling_q && bus_err_i)
      begin
        // abort, line never written
        filling_q <= 1'b0;
      end
      else if (filling_q && bus_ack_i)
      begin
        cnt_q <= cnt_q + 1'b1;
        if (last_word)
        begin
          filling_q <= 1'b0;
          we_q      <= 1'b1;
        end
      end
    end
  end

  // line base and gathered words
  always_ff @(posedge clk_i)
  begin
    if (cmd_i == CMD_READLINE)
    begin
      base_q <= adr_i[PLEN-1 -: BASE_W];
    end
    if (filling_q && bus_ack_i)
    begin
      line_q[cnt_q*XLEN +: XLEN] <= bus_q_i;
    end
  end

  //////////////////////////////////////////////////
  // bus side
  //////////////////////////////////////////////////

  // one word at a time, level held until ack or err
  assign bus_req_o = filling_q | nc_req_i;
  assign bus_adr_o = filling_q ? {base_q, cnt_q, 2'b00} : {adr_i[PLEN-1:2], 2'b00};

  // storage write the cycle after the last ack
  assign fill_we_o   = we_q;
  assign fill_done_o = we_q;
  assign fill_idx_o  = base_q[IDX_W-1:0];
  assign fill_tag_o  = base_q[BASE_W-1 -: TAG_W];
  assign fill_line_o = line_q;

  // error covers both line fills and single reads
  assign fill_err_o = bus_err_i & (filling_q | nc_req_i);

  // single non-cacheable word straight to the core
  assign word_ack_o = bus_ack_i & nc_req_i & ~filling_q;
  assign word_o     = bus_q_i;

endmodule

// File: cache_store.sv
`timescale 1ns/1ps

module cache_store import icache_pkg::*; #(
  parameter int WAYS       = 2,
  parameter int SETS       = 16,
  parameter int LINE_WORDS = 4
) (
  input  logic                                  clk_i,
  input  logic                                  rst_ni,
  input  logic [idx_bits(SETS)-1:0]             idx_i,
  input  logic [tag_bits(SETS, LINE_WORDS)-1:0] tag_i,
  input  logic                                  fill_we_i,
  input  logic [idx_bits(SETS)-1:0]             fill_idx_i,
  input  logic [tag_bits(SETS, LINE_WORDS)-1:0] fill_tag_i,
  input  logic [LINE_WORDS*XLEN-1:0]            fill_line_i,
  input  logic                                  flush_all_i,
  output logic                                  hit_o,
  output logic [LINE_WORDS*XLEN-1:0]            hit_line_o
);

  localparam int TAG_W  = tag_bits(SETS, LINE_WORDS);
  localparam int LINE_W = LINE_WORDS * XLEN;
  localparam int WAY_W  = (WAYS > 1) ? $clog2(WAYS) : 1;

  // valid bits packed per set, one per way
  logic [WAYS-1:0]   valid_q [SETS];
  logic [TAG_W-1:0]  tag_q   [WAYS][SETS];
  logic [LINE_W-1:0] data_q  [WAYS][SETS];
  // round-robin victim pointer per set
  logic [WAY_W-1:0]  rr_q    [SETS];
  logic [WAY_W-1:0]  victim;
  logic [WAYS-1:0]   way_hit;

  //////////////////////////////////////////////////
  // lookup
  //////////////////////////////////////////////////

  // all ways compared in parallel
  always_comb
  begin
    hit_line_o = '0;
    for (int w = 0; w < WAYS; w++)
    begin
      way_hit[w] = valid_q[idx_i][w] && (tag_q[w][idx_i] == tag_i);
      // at most one way matches, so OR-ing is a mux
      if (way_hit[w])
      begin
        hit_line_o = hit_line_o | data_q[w][idx_i];
      end
    end
  end

  assign hit_o = |way_hit;

  //////////////////////////////////////////////////
  // valid bits and replacement
  //////////////////////////////////////////////////

  assign victim = rr_q[fill_idx_i];

  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      for (int s = 0; s < SETS; s++)
      begin
        valid_q[s] <= '0;
        rr_q[s]    <= '0;
      end
    end
    else if (flush_all_i)
    begin
      // whole cache invalid in one cycle
      for (int s = 0; s < SETS; s++)
      begin
        valid_q[s] <= '0;
      end
    end
    else if (fill_we_i)
    begin
      valid_q[fill_idx_i][victim] <= 1'b1;
      // step to next way, wrap at WAYS
      rr_q[fill_idx_i] <= (victim == WAY_W'(WAYS - 1)) ? '0 : victim + 1'b1;
    end
  end

  // tag and line storage
  always_ff @(posedge clk_i)
  begin
    if (fill_we_i)
    begin
      tag_q[victim][fill_idx_i]  <= fill_tag_i;
      data_q[victim][fill_idx_i] <= fill_line_i;
    end
  end

endmodule

// File: cache_req_decode.sv
`timescale 1ns/1ps

module cache_req_decode import icache_pkg::*; #(
  parameter int SETS       = 16,
  parameter int LINE_WORDS = 4
) (
  input  logic                                  req_i,
  input  logic [PLEN-1:0]                       adr_i,
  input  logic                                  cacheable_i,
  input  logic                                  misaligned_i,
  input  logic                                  pagefault_i,
  input  logic                                  access_fault_i,
  output logic                                  valid_req_o,
  output logic                                  valid_cacheable_o,
  output logic                                  valid_nc_o,
  output logic [idx_bits(SETS)-1:0]             idx_o,
  output logic [tag_bits(SETS, LINE_WORDS)-1:0] tag_o,
  output logic [offs_bits(LINE_WORDS)-1:0]      offs_o,
  output logic                                  misaligned_o,
  output logic                                  pagefault_o,
  output logic                                  fault_o
);

  localparam int IDX_W  = idx_bits(SETS);
  localparam int OFFS_W = offs_bits(LINE_WORDS);
  localparam int TAG_W  = tag_bits(SETS, LINE_WORDS);

  logic faulted;

  //////////////////////////////////////////////////
  // request qualification
  //////////////////////////////////////////////////

  // any fault kills the request before it reaches the FSM
  assign faulted     = misaligned_i | pagefault_i | access_fault_i;
  assign valid_req_o = req_i & ~faulted;

  // split by memory attribute
  assign valid_cacheable_o = valid_req_o & cacheable_i;
  assign valid_nc_o        = valid_req_o & ~cacheable_i;

  // fault flags only count with a request
  assign misaligned_o = req_i & misaligned_i;
  assign pagefault_o  = req_i & pagefault_i;
  assign fault_o      = req_i & access_fault_i;

  //////////////////////////////////////////////////
  // address fields
  //////////////////////////////////////////////////

  // byte lane [1:0], then word offset, then set index
  assign offs_o = adr_i[2 +: OFFS_W];
  assign idx_o  = adr_i[2 + OFFS_W +: IDX_W];
  assign tag_o  = adr_i[PLEN-1 -: TAG_W];

endmodule

// File: icache_pkg.sv
package icache_pkg;

  //////////////////////////////////////////////////
  // widths
  //////////////////////////////////////////////////

  // core data and physical address
  localparam int XLEN = 32;
  localparam int PLEN = 32;

  //////////////////////////////////////////////////
  // enums
  //////////////////////////////////////////////////

  // hit stage states
  typedef enum logic [2:0] {
    ARMED        = 3'd0,
    FLUSH        = 3'd1,
    NONCACHEABLE = 3'd2,
    READ         = 3'd3,
    RECOVER0     = 3'd4,
    RECOVER1     = 3'd5
  } hit_state_e;

  // command to the fill sequencer
  typedef enum logic {
    CMD_NOP      = 1'b0,
    CMD_READLINE = 1'b1
  } bus_cmd_e;

  //////////////////////////////////////////////////
  // address field helpers
  //////////////////////////////////////////////////

  // set index bits
  function automatic int idx_bits(input int sets);
    return $clog2(sets);
  endfunction

  // word-in-line bits
  function automatic int offs_bits(input int line_words);
    return $clog2(line_words);
  endfunction

  // what is left above index, offset and byte lane
  function automatic int tag_bits(input int sets, input int line_words);
    return PLEN - idx_bits(sets) - offs_bits(line_words) - 2;
  endfunction

endpackage
